/* tb.f */
src/decoder_pkg.sv
src/stage_if.sv
src/stage_controller.sv
src/measurement_loader.sv
src/decode_stats.sv
src/correction_fifo.sv
src/result_serializer.sv
src/decoder_controller.sv
tests/tb_clock.sv
tests/decoder_props.sv
tests/tb_decoder_controller.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the decoder controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
    --top-module tb_decoder_controller \
    -f tb.f --Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -q "Finished with no errors" "$LOG"; then
    exit 0
fi
exit 1

/* tests/tb_decoder_controller.sv */
`timescale 1ns/100ps

module tb_decoder_controller;
    import decoder_pkg::*;

    localparam GX = 4, GZ = 1, GU = 3, MAX_DELAY = 2;
    localparam PE_COUNT  = GX * GZ * GU;
    localparam CORR_BITS = 2 * (GX - 1) * GZ + 1 + GX * GZ;
    localparam OUT_BYTES = HEADER_BYTES + GU * 2;
    localparam NUM_ROWS  = 4;
    localparam LIMIT     = (NUM_ROWS + 1) * 200;

    typedef struct {
        string       name;
        logic [23:0] meas;   // round 0 in the low byte
        int          k;      // merges with odd clusters
        int          busy;   // busy cycles after each grow
        bit          toggle; // out_ready from the LFSR
    } row_t;

    logic clk, reset;
    logic [CTRL_WIDTH-1:0] ctrl_rx_data;
    logic ctrl_rx_valid, ctrl_rx_ready;
    logic [7:0] data_in, out_data, measurements;
    logic data_valid, data_ready, out_valid, out_ready;
    logic [PE_COUNT-1:0] busy_pe, odd_clusters_pe;
    logic [CORR_BITS-1:0] correction;
    stage_t global_stage;

    row_t rows[NUM_ROWS];
    logic [CORR_BITS-1:0] words[GU];
    logic [7:0] out_q[$];
    logic [15:0] data_lfsr, rdy_lfsr;
    int errors, checks, cycles, grows_seen, busy_left, res_idx;
    int k_cur, busy_cur, cyc_row[NUM_ROWS];
    bit toggle_cur;
    logic [7:0] hdr_ref[3];

    tb_clock #(.PERIOD(10), .RESET_CYCLES(3)) clkgen (.clk, .reset);

    decoder_controller #(
        .GRID_WIDTH_X(GX), .GRID_WIDTH_Z(GZ), .GRID_WIDTH_U(GU),
        .MAXIMUM_DELAY(MAX_DELAY), .FIFO_DEPTH(32)
    ) DUT (
        .clk, .reset, .ctrl_rx_data, .ctrl_rx_valid, .ctrl_rx_ready,
        .data_in, .data_valid, .data_ready, .out_data, .out_valid, .out_ready,
        .busy_pe, .odd_clusters_pe, .correction, .measurements, .global_stage
    );

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic check(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // PE model and correction source
    always @(posedge clk) begin
        if (global_stage == STAGE_GROW) begin
            grows_seen++;
            busy_left = busy_cur;
            odd_clusters_pe <= (grows_seen <= k_cur) ? '1 : '0;
        end else if (busy_left > 0) begin
            busy_left--;
        end
        busy_pe <= (busy_left > 0) ? '1 : '0;
        if (global_stage == STAGE_RESULT_VALID && res_idx < GU) begin
            correction <= words[res_idx]; // taken by the FIFO a cycle later
            res_idx++;
        end
    end

    always @(posedge clk) begin
        if (out_valid && out_ready) out_q.push_back(out_data);
        if (toggle_cur) begin
            rdy_lfsr = lfsr_step(rdy_lfsr);
            out_ready <= rdy_lfsr[0];
        end else begin
            out_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: no complete result after %0d cycles", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic send_ctrl(input logic [7:0] hdr);
        ctrl_rx_data  <= CTRL_WIDTH'(hdr) << (CTRL_HEADER_MSB - 7);
        ctrl_rx_valid <= 1'b1;
        do @(posedge clk); while (!ctrl_rx_ready);
        ctrl_rx_valid <= 1'b0;
    endtask

    task automatic send_byte(input string name, input logic [7:0] b);
        data_in    <= b;
        data_valid <= 1'b1;
        do @(posedge clk); while (!data_ready);
        data_valid <= 1'b0;
        @(posedge clk);
        check({name, "_meas"}, b, measurements);
    endtask

    task automatic run_decode(input int i);
        int lo;
        int hi;
        for (int w = 0; w < GU; w++) begin
            for (int b = 0; b < CORR_BITS; b++) begin
                data_lfsr = lfsr_step(data_lfsr);
                words[w][b] = data_lfsr[0];
            end
        end
        out_q.delete();
        grows_seen = 0;
        res_idx    = 0;
        k_cur      = rows[i].k;
        busy_cur   = rows[i].busy;
        toggle_cur = rows[i].toggle;
        send_ctrl(MEASUREMENT_DATA_HEADER);
        for (int r = 0; r < GU; r++) send_byte(rows[i].name, rows[i].meas[r*8 +: 8]);
        while (out_q.size() < OUT_BYTES) @(posedge clk);
        repeat (4) @(posedge clk);
        check({rows[i].name, "_count"}, OUT_BYTES, out_q.size());
        check({rows[i].name, "_iter"}, rows[i].k + 1, out_q[0]);
        cyc_row[i] = {out_q[1], out_q[2]};
        check({rows[i].name, "_cycles_min"}, 1,
              cyc_row[i] >= (rows[i].k + 1) * (MAX_DELAY + 2) + 2);
        for (int w = 0; w < GU; w++) begin
            lo = words[w][7:0];
            hi = words[w][CORR_BITS-1:8];
            check($sformatf("%s_corr%0d_lo", rows[i].name, w), lo, out_q[3 + 2*w]);
            check($sformatf("%s_corr%0d_hi", rows[i].name, w), hi, out_q[4 + 2*w]);
        end
        toggle_cur = 1'b0;
    endtask

    initial begin
        ctrl_rx_data    = '0;
        ctrl_rx_valid   = 1'b0;
        data_in         = '0;
        data_valid      = 1'b0;
        out_ready       = 1'b1;
        busy_pe         = '0;
        odd_clusters_pe = '0;
        correction      = '0;
        data_lfsr       = 16'd1881;
        rdy_lfsr        = 16'd1881;
        toggle_cur      = 1'b0;
        k_cur           = 0;
        busy_cur        = 0;
        rows[0] = '{"k0_plain", 24'h5a_c3_0f, 0, 1, 1'b0};
        rows[1] = '{"k2_short", 24'h81_7e_33, 2, 1, 1'b0};
        rows[2] = '{"k2_long", 24'h0c_f0_a5, 2, 8, 1'b0};
        rows[3] = '{"k2_long_stall", 24'h0c_f0_a5, 2, 8, 1'b1};

        do @(posedge clk); while (reset);
        @(posedge clk);
        check("reset_stage", STAGE_IDLE, global_stage);
        check("reset_ctrl_ready", 1, ctrl_rx_ready);
        check("reset_data_ready", 0, data_ready);
        check("reset_out_valid", 0, out_valid);

        send_ctrl(8'h05); // not a measurement header
        repeat (3) @(posedge clk);
        check("other_header_stage", STAGE_IDLE, global_stage);

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_decode(i);
            if (i == 2) begin
                for (int h = 0; h < 3; h++) hdr_ref[h] = out_q[h];
            end
        end
        check("busy_longer_cycles", 1, cyc_row[2] > cyc_row[1]);
        // stalled sink gives the same header as the free one
        for (int h = 0; h < 3; h++) begin
            check($sformatf("stall_header%0d", h), hdr_ref[h], out_q[h]);
        end

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* tests/decoder_props.sv */
`timescale 1ns/100ps

module decoder_props (
    input logic                clk,
    input logic                reset,
    input logic [7:0]          out_data,
    input logic                out_valid,
    input logic                out_ready,
    input logic                data_ready,
    input decoder_pkg::stage_t global_stage,
    input logic                fifo_write,
    input logic                fifo_full
);
    import decoder_pkg::*;

    // byte held while the sink stalls
    out_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("out_data changed while stalled");

    ready_stage: assert property (@(posedge clk) disable iff (reset)
        data_ready |-> global_stage == STAGE_MEASUREMENT_PREPARING)
        else $error("data_ready outside PREPARING");

    no_overflow: assert property (@(posedge clk) disable iff (reset)
        !(fifo_write && fifo_full))
        else $error("correction FIFO written while full");

endmodule

bind decoder_controller decoder_props props (
    .clk          (clk),
    .reset        (reset),
    .out_data     (out_data),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .data_ready   (data_ready),
    .global_stage (global_stage),
    .fifo_write   (u_fifo.wr_strobe),
    .fifo_full    (u_fifo.full)
);

/* tests/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
    parameter PERIOD       = 10,
    parameter RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* src/decoder_controller.sv */
`timescale 1ns/100ps

module decoder_controller #(
    parameter GRID_WIDTH_X  = 4,
    parameter GRID_WIDTH_Z  = 1,
    parameter GRID_WIDTH_U  = 3,
    parameter MAXIMUM_DELAY = 2,
    parameter FIFO_DEPTH    = 32
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [decoder_pkg::CTRL_WIDTH-1:0] ctrl_rx_data,
    input  logic                               ctrl_rx_valid,
    output logic                               ctrl_rx_ready,
    input  logic [decoder_pkg::BYTE_WIDTH-1:0] data_in,
    input  logic                               data_valid,
    output logic                               data_ready,
    output logic [decoder_pkg::BYTE_WIDTH-1:0] out_data,
    output logic                               out_valid,
    input  logic                               out_ready,
    input  logic [GRID_WIDTH_X*GRID_WIDTH_Z*GRID_WIDTH_U-1:0] busy_pe,
    input  logic [GRID_WIDTH_X*GRID_WIDTH_Z*GRID_WIDTH_U-1:0] odd_clusters_pe,
    input  logic [2*(GRID_WIDTH_X-1)*GRID_WIDTH_Z+1+GRID_WIDTH_X*GRID_WIDTH_Z-1:0] correction,
    output logic [((GRID_WIDTH_X*GRID_WIDTH_Z+7)/8)*8-1:0] measurements,
    output decoder_pkg::stage_t                global_stage
);
    import decoder_pkg::*;

    // ns + ew (with the extra boundary edge) + ud errors per round
    localparam CORRECTION_BITS = 2 * (GRID_WIDTH_X - 1) * GRID_WIDTH_Z + 1
                               + GRID_WIDTH_X * GRID_WIDTH_Z;

    logic [ITER_WIDTH-1:0]      iteration_count;
    logic [COUNT_WIDTH-1:0]     cycle_count;
    logic [CORRECTION_BITS-1:0] fifo_data;
    logic                       fifo_valid;
    logic                       fifo_ready;

    stage_if sif ();

    assign global_stage = sif.stage;

    stage_controller #(
        .GRID_WIDTH_X(GRID_WIDTH_X), .GRID_WIDTH_Z(GRID_WIDTH_Z),
        .GRID_WIDTH_U(GRID_WIDTH_U), .MAXIMUM_DELAY(MAXIMUM_DELAY)
    ) u_stage (
        .clk, .reset, .ctrl_rx_data, .ctrl_rx_valid, .ctrl_rx_ready,
        .busy_pe, .odd_clusters_pe, .st(sif.ctrl)
    );

    measurement_loader #(
        .GRID_WIDTH_X(GRID_WIDTH_X), .GRID_WIDTH_Z(GRID_WIDTH_Z),
        .GRID_WIDTH_U(GRID_WIDTH_U)
    ) u_loader (
        .clk, .reset, .data_in, .data_valid, .data_ready, .measurements,
        .st(sif.loader)
    );

    decode_stats u_stats (
        .clk, .reset, .st(sif.stats), .iteration_count, .cycle_count
    );

    correction_fifo #(.WIDTH(CORRECTION_BITS), .DEPTH(FIFO_DEPTH)) u_fifo (
        .clk, .reset, .wr_data(correction), .wr_en(sif.result_round),
        .rd_data(fifo_data), .rd_valid(fifo_valid), .rd_ready(fifo_ready)
    );

    result_serializer #(
        .WORD_WIDTH(CORRECTION_BITS), .WORDS_PER_DECODE(GRID_WIDTH_U)
    ) u_serializer (
        .clk, .reset, .word_data(fifo_data), .word_valid(fifo_valid),
        .word_ready(fifo_ready), .iteration_count, .cycle_count,
        .out_data, .out_valid, .out_ready
    );

endmodule

/* src/result_serializer.sv */
`timescale 1ns/100ps

module result_serializer #(
    parameter WORD_WIDTH       = 11,
    parameter WORDS_PER_DECODE = 3
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [WORD_WIDTH-1:0]               word_data,
    input  logic                                word_valid,
    output logic                                word_ready,
    input  logic [decoder_pkg::ITER_WIDTH-1:0]  iteration_count,
    input  logic [decoder_pkg::COUNT_WIDTH-1:0] cycle_count,
    output logic [decoder_pkg::BYTE_WIDTH-1:0]  out_data,
    output logic                                out_valid,
    input  logic                                out_ready
);
    import decoder_pkg::*;

    localparam BYTES_PER_WORD = (WORD_WIDTH + 7) / 8;
    localparam TOTAL_BYTES    = HEADER_BYTES + WORDS_PER_DECODE * BYTES_PER_WORD;
    localparam BYTE_CNT_WIDTH = $clog2(TOTAL_BYTES + 1);
    localparam SLICE_WIDTH    = $clog2(BYTES_PER_WORD + 1);

    logic [BYTE_CNT_WIDTH-1:0]            byte_cnt;  // bytes sent in this decode
    logic [SLICE_WIDTH-1:0]               slice_idx; // byte within the head word
    logic [BYTES_PER_WORD*BYTE_WIDTH-1:0] padded;
    logic                                 in_header;
    logic                                 fire;

    assign in_header  = (byte_cnt < HEADER_BYTES);
    // header waits for the first word of the decode to reach the head
    assign out_valid  = word_valid;
    assign fire       = out_valid && out_ready;
    assign word_ready = fire && !in_header && (slice_idx == BYTES_PER_WORD - 1);

    always_comb begin
        padded = '0;
        padded[WORD_WIDTH-1:0] = word_data;
        case (byte_cnt)
            0:       out_data = iteration_count;
            1:       out_data = cycle_count[COUNT_WIDTH-1:BYTE_WIDTH];
            2:       out_data = cycle_count[BYTE_WIDTH-1:0];
            default: out_data = padded[slice_idx*BYTE_WIDTH +: BYTE_WIDTH]; // lsb first
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            byte_cnt  <= '0;
            slice_idx <= '0;
        end else if (fire) begin
            if (byte_cnt == TOTAL_BYTES - 1) begin
                byte_cnt <= '0;
            end else begin
                byte_cnt <= byte_cnt + 1'b1;
            end
            if (!in_header) begin
                if (slice_idx == BYTES_PER_WORD - 1) begin
                    slice_idx <= '0;
                end else begin
                    slice_idx <= slice_idx + 1'b1;
                end
            end
        end
    end

endmodule

/* src/correction_fifo.sv */
`timescale 1ns/100ps

module correction_fifo #(
    parameter WIDTH = 11,
    parameter DEPTH = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             wr_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             rd_valid,
    input  logic             rd_ready
);
    localparam PTR_WIDTH   = $clog2(DEPTH);
    localparam COUNT_WIDTH = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]       mem [DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   wr_strobe; // wr_en one cycle late
    logic                   full;
    logic                   do_write;
    logic                   do_read;

    // the PEs present a round's correction the cycle after its result round
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_strobe <= 1'b0;
        end else begin
            wr_strobe <= wr_en;
        end
    end

    assign full     = (count == DEPTH);
    assign rd_valid = (count != 0);
    assign rd_data  = mem[rd_ptr];
    assign do_write = wr_strobe && !full; // dropped when full
    assign do_read  = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* src/decode_stats.sv */
`timescale 1ns/100ps

module decode_stats (
    input  logic                               clk,
    input  logic                               reset,
    stage_if.stats                             st,
    output logic [decoder_pkg::ITER_WIDTH-1:0]  iteration_count,
    output logic [decoder_pkg::COUNT_WIDTH-1:0] cycle_count
);
    import decoder_pkg::*;

    stage_t prev_stage;
    logic   cycle_on;

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_stage <= STAGE_IDLE;
        end else begin
            prev_stage <= st.stage;
        end
    end

    // one count per entry into GROW
    always_ff @(posedge clk) begin
        if (reset) begin
            iteration_count <= '0;
        end else if (st.stage == STAGE_MEASUREMENT_LOADING) begin
            iteration_count <= '0;
        end else if (st.stage == STAGE_GROW && prev_stage != STAGE_GROW) begin
            iteration_count <= iteration_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_count <= '0;
            cycle_on    <= 1'b0;
        end else if (st.grow_start) begin
            cycle_count <= COUNT_WIDTH'(2); // controller to PE propagation
            cycle_on    <= 1'b1;
        end else if (st.result_round) begin
            cycle_on <= 1'b0; // holds from the first result round
        end else if (cycle_on) begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

endmodule

/* src/measurement_loader.sv */
`timescale 1ns/100ps

module measurement_loader #(
    parameter GRID_WIDTH_X = 4,
    parameter GRID_WIDTH_Z = 1,
    parameter GRID_WIDTH_U = 3
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [decoder_pkg::BYTE_WIDTH-1:0] data_in,
    input  logic                              data_valid,
    output logic                              data_ready,
    output logic [((GRID_WIDTH_X*GRID_WIDTH_Z+7)/8)*8-1:0] measurements,
    stage_if.loader                           st
);
    import decoder_pkg::*;

    localparam BYTES_PER_ROUND = (GRID_WIDTH_X * GRID_WIDTH_Z + 7) / 8;
    localparam ALIGNED_BITS    = BYTES_PER_ROUND * 8;
    localparam BYTE_CNT_WIDTH  = $clog2(BYTES_PER_ROUND + 1);
    localparam ROUND_WIDTH     = $clog2(GRID_WIDTH_U + 1);

    logic [BYTE_CNT_WIDTH-1:0]          byte_cnt;
    logic [ROUND_WIDTH-1:0]             round_cnt;
    logic                               accept;
    logic [ALIGNED_BITS+BYTE_WIDTH-1:0] shifted;

    assign data_ready = (st.stage == STAGE_MEASUREMENT_PREPARING);
    assign accept     = data_valid && data_ready;
    assign st.round_done      = accept && (byte_cnt == BYTES_PER_ROUND - 1);
    assign st.all_rounds_done = (round_cnt == GRID_WIDTH_U);

    // new byte enters at the top, older bytes move down
    assign shifted = {data_in, measurements};

    always_ff @(posedge clk) begin
        if (accept) begin
            measurements <= shifted[ALIGNED_BITS+BYTE_WIDTH-1:BYTE_WIDTH];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            byte_cnt  <= '0;
            round_cnt <= '0;
        end else if (st.stage == STAGE_IDLE) begin
            byte_cnt  <= '0; // fresh decode
            round_cnt <= '0;
        end else if (st.round_done) begin
            byte_cnt  <= '0;
            round_cnt <= round_cnt + 1'b1;
        end else if (accept) begin
            byte_cnt <= byte_cnt + 1'b1;
        end
    end

endmodule

/* src/stage_controller.sv */
`timescale 1ns/100ps

module stage_controller #(
    parameter GRID_WIDTH_X  = 4,
    parameter GRID_WIDTH_Z  = 1,
    parameter GRID_WIDTH_U  = 3,
    parameter MAXIMUM_DELAY = 2
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [decoder_pkg::CTRL_WIDTH-1:0] ctrl_rx_data,
    input  logic                            ctrl_rx_valid,
    output logic                            ctrl_rx_ready,
    input  logic [GRID_WIDTH_X*GRID_WIDTH_Z*GRID_WIDTH_U-1:0] busy_pe,
    input  logic [GRID_WIDTH_X*GRID_WIDTH_Z*GRID_WIDTH_U-1:0] odd_clusters_pe,
    stage_if.ctrl                           st
);
    import decoder_pkg::*;

    localparam DELAY_WIDTH = $clog2(MAXIMUM_DELAY + 2);
    localparam ROUND_WIDTH = $clog2(GRID_WIDTH_U + 1);

    logic [DELAY_WIDTH-1:0] delay_cnt;
    logic [ROUND_WIDTH-1:0] result_cnt;
    logic                   busy;
    logic                   odd_clusters;
    logic [BYTE_WIDTH-1:0]  header;

    assign header        = ctrl_rx_data[CTRL_HEADER_MSB -: BYTE_WIDTH];
    assign ctrl_rx_ready = (st.stage == STAGE_IDLE);
    assign st.result_round = (st.stage == STAGE_RESULT_VALID);

    // PE reductions, one cycle behind the array
    always_ff @(posedge clk) begin
        if (reset) begin
            busy         <= 1'b0;
            odd_clusters <= 1'b0;
        end else begin
            busy         <= |busy_pe;
            odd_clusters <= |odd_clusters_pe;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            st.stage      <= STAGE_IDLE;
            st.grow_start <= 1'b0;
            delay_cnt     <= '0;
            result_cnt    <= '0;
        end else begin
            st.grow_start <= 1'b0;
            case (st.stage)
                STAGE_IDLE: begin
                    // other message types are dropped here
                    if (ctrl_rx_valid && header == MEASUREMENT_DATA_HEADER) begin
                        st.stage <= STAGE_MEASUREMENT_PREPARING;
                    end
                end
                STAGE_MEASUREMENT_PREPARING: begin
                    if (st.round_done) begin
                        st.stage <= STAGE_MEASUREMENT_LOADING;
                    end
                end
                STAGE_MEASUREMENT_LOADING: begin
                    if (st.all_rounds_done) begin
                        st.stage      <= STAGE_GROW;
                        st.grow_start <= 1'b1;
                    end else begin
                        st.stage <= STAGE_MEASUREMENT_PREPARING;
                    end
                end
                STAGE_GROW: begin
                    st.stage  <= STAGE_MERGE;
                    delay_cnt <= '0;
                end
                STAGE_MERGE: begin
                    if (delay_cnt >= MAXIMUM_DELAY) begin
                        if (!busy) begin
                            // another grow while any cluster is still odd
                            st.stage <= odd_clusters ? STAGE_GROW : STAGE_PEELING;
                        end
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                STAGE_PEELING: begin
                    st.stage   <= STAGE_RESULT_VALID;
                    result_cnt <= '0;
                end
                STAGE_RESULT_VALID: begin
                    result_cnt <= result_cnt + 1'b1;
                    if (result_cnt == GRID_WIDTH_U - 1) begin
                        st.stage <= STAGE_IDLE;
                    end
                end
                default: st.stage <= STAGE_IDLE;
            endcase
        end
    end

endmodule

/* src/stage_if.sv */
`timescale 1ns/100ps

interface stage_if;
    import decoder_pkg::*;

    stage_t stage;
    logic   grow_start;      // first GROW cycle of a decode
    logic   result_round;    // high in every RESULT_VALID cycle
    logic   round_done;      // last byte of a round accepted
    logic   all_rounds_done;

    modport ctrl (
        output stage, grow_start, result_round,
        input  round_done, all_rounds_done
    );

    modport loader (
        input  stage,
        output round_done, all_rounds_done
    );

    modport stats (
        input stage, grow_start, result_round
    );

endinterface

/* src/decoder_pkg.sv */
package decoder_pkg;

    // stage encoding, codes 1 and 6 unused
    typedef enum logic [3:0] {
        STAGE_IDLE                  = 4'd0,
        STAGE_GROW                  = 4'd2,
        STAGE_MERGE                 = 4'd3,
        STAGE_PEELING               = 4'd4,
        STAGE_RESULT_VALID          = 4'd5,
        STAGE_MEASUREMENT_PREPARING = 4'd7,
        STAGE_MEASUREMENT_LOADING   = 4'd8
    } stage_t;

    // header byte of a control word that starts a decode
    localparam logic [7:0] MEASUREMENT_DATA_HEADER = 8'd1;

    // control word layout
    localparam int CTRL_WIDTH      = 64;
    localparam int CTRL_HEADER_MSB = 47; // header byte is [47:40]

    // byte channels
    localparam int BYTE_WIDTH = 8;

    // result header counters
    localparam int COUNT_WIDTH = 16;
    localparam int ITER_WIDTH  = 8;

    // iteration count, cycle count high, cycle count low
    localparam int HEADER_BYTES = 3;

endpackage
